// ==== bench/pe_assert.sv ====
//==========================================================================
// Usage and flag rules of pe_top, sampled on the rising clock edge
// All checks are idle while rst_n is low
//==========================================================================
`timescale 1ns/1ps

module pe_assert (
    input logic clk,
    input logic rst_n,
    input logic tap_push,
    input logic busy,
    input logic ipsum_full,
    input logic ipsum_empty,
    input logic opsum_valid
);

    // Taps pushed while busy are lost by the MAC
    tap_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
        !(tap_push && busy))
        else $error("tap_push while busy is high");

    // Full and empty exclude each other for any depth of 2 or more
    full_and_empty: assert property (@(posedge clk) disable iff (!rst_n)
        !(ipsum_full && ipsum_empty))
        else $error("ipsum_full and ipsum_empty high together");

    opsum_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        opsum_valid |=> !opsum_valid)
        else $error("opsum_valid held longer than one cycle");

endmodule

bind pe_top pe_assert i_pe_assert (
    .clk         (clk),
    .rst_n       (rst_n),
    .tap_push    (tap_push),
    .busy        (busy),
    .ipsum_full  (ipsum_full),
    .ipsum_empty (ipsum_empty),
    .opsum_valid (opsum_valid)
);

// ==== bench/pe_tb.sv ====
//==========================================================================
// Testbench for pe_top, commands and expected values from bench/pe_tests.txt
// Must run from the project root so the data file path resolves
// Reference model keeps its own ipsum queue with the FIFO acceptance rules
//==========================================================================
`timescale 1ns/1ps

module pe_tb;
    import pe_pkg::*;

    localparam int FIFO_DEPTH = 4;
    localparam int TIMEOUT    = 200;       // Cycles allowed per wait

    logic                  clk;
    logic                  rst_n;
    logic                  cfg_write;
    logic [CFG_ADDR_W-1:0] cfg_addr;
    logic [7:0]            cfg_wdata;
    logic [7:0]            cfg_rdata;
    logic                  tap_push;
    logic [ACT_W-1:0]      tap_ifmap;
    logic [ACT_W-1:0]      tap_weight;
    logic                  ipsum_push;
    logic                  ipsum_burst;
    psum_pair_u            ipsum_data;
    logic                  ipsum_clear;
    logic                  opsum_valid;
    logic [PSUM_W-1:0]     opsum;
    logic                  busy;
    logic                  ipsum_full;
    logic                  ipsum_empty;

    logic [PSUM_W-1:0] ipsum_q[$];     // Accepted ipsums, head first
    logic [PSUM_W-1:0] opsum_q[$];     // Opsums caught from the DUT
    logic [TAPS_W-1:0] taps_m;         // Model config
    logic              ipsum_en_m;
    logic [PSUM_W-1:0] sum_m;          // Products of the last tap window

    int          fd;
    int          scan_n;
    int          errors;
    int          checks;
    int          tests;
    int          failed;
    int          test_errs;
    string       tname;                // Name on the current line
    string       cur_name;
    string       cmd;
    logic [31:0] a;                    // File operands
    logic [31:0] b;

    pe_top #(.FIFO_DEPTH(FIFO_DEPTH)) i_dut (.*);

    always #5 clk = ~clk;

    // Catch every opsum pulse, sampled away from the rising edge
    always @(negedge clk) begin
        if (rst_n && opsum_valid)
            opsum_q.push_back(opsum);
    end

    //======================================================================
    // Reporting
    task automatic report_fail(input string msg);
        $display("%s (test %s)", msg, tname);
        errors++;
        test_errs++;
    endtask

    task automatic check_val(input string what, input logic [31:0] exp,
                             input logic [31:0] act);
        checks++;
        assert (act == exp) else begin
            $display("ERROR %s %s: expected %h, actual %h", tname, what, exp, act);
            errors++;
            test_errs++;
        end
    endtask

    task automatic finish_test();
        if (cur_name != "") begin
            tests++;
            if (test_errs > 0) begin
                failed++;
                $display("Test %s failed with %0d errors", cur_name, test_errs);
            end else begin
                $display("Test %s passed", cur_name);
            end
        end
        test_errs = 0;
    endtask

    task automatic skip_line();
        int c;
        c = $fgetc(fd);
        while (c != 10 && c != -1)     // Up to newline or end of file
            c = $fgetc(fd);
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        @(negedge clk);
        while (busy && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        assert (!busy) else report_fail("Timeout, busy stayed high");
    endtask

    //======================================================================
    // Commands
    task automatic do_cfg();
        scan_n = $fscanf(fd, "%h %h", a, b);
        @(posedge clk);
        cfg_write <= 1'b1;
        cfg_addr  <= a[CFG_ADDR_W-1:0];
        cfg_wdata <= b[7:0];
        @(posedge clk);
        cfg_write <= 1'b0;
        if (a == 32'(CFG_TAPS_ADDR))   // Zero count behaves as one tap
            taps_m = (b[TAPS_W-1:0] == '0) ? TAPS_W'(1) : b[TAPS_W-1:0];
        else if (a == 32'(CFG_CTRL_ADDR))
            ipsum_en_m = b[0];
    endtask

    task automatic do_read();
        logic [7:0] exp;
        scan_n = $fscanf(fd, "%h %h", a, b);
        @(posedge clk);
        cfg_addr <= a[CFG_ADDR_W-1:0];
        @(negedge clk);
        if (a == 32'(CFG_TAPS_ADDR))
            exp = 8'(taps_m);
        else if (a == 32'(CFG_CTRL_ADDR))
            exp = {7'd0, ipsum_en_m};
        else
            exp = 8'd0;                // Unmapped address
        assert (b == 32'(exp)) else report_fail("Data file readback differs from model");
        check_val("cfg_rdata", 32'(exp), 32'(cfg_rdata));
    endtask

    task automatic do_push(input logic burst);
        psum_pair_u word;
        word.raw = '0;
        scan_n = $fscanf(fd, "%h", a);
        word.lanes.lo = a[PSUM_W-1:0];
        if (burst) begin
            scan_n = $fscanf(fd, "%h", b);
            word.lanes.hi = b[PSUM_W-1:0];
        end
        @(posedge clk);
        ipsum_push  <= 1'b1;
        ipsum_burst <= burst;
        ipsum_data  <= word;
        @(posedge clk);
        ipsum_push  <= 1'b0;
        ipsum_burst <= 1'b0;
        // Burst only into an empty queue, single only below depth
        if (burst && ipsum_q.size() == 0) begin
            ipsum_q.push_back(word.lanes.lo);
            ipsum_q.push_back(word.lanes.hi);
        end else if (!burst && ipsum_q.size() < FIFO_DEPTH) begin
            ipsum_q.push_back(word.lanes.lo);
        end
    endtask

    task automatic do_clear();
        @(posedge clk);
        ipsum_clear <= 1'b1;
        @(posedge clk);
        ipsum_clear <= 1'b0;
        ipsum_q.delete();
    endtask

    task automatic do_taps();
        logic [31:0]        n;
        logic [31:0]        i;
        logic [31:0]        ifm;
        logic [31:0]        wgt;
        logic signed [15:0] prod;
        scan_n = $fscanf(fd, "%h", n);
        assert (n == 32'(taps_m)) else report_fail("Tap count differs from configured taps");
        wait_idle();
        sum_m = '0;
        for (i = 0; i < n; i++) begin
            scan_n = $fscanf(fd, "%h %h", ifm, wgt);
            @(posedge clk);
            tap_push   <= 1'b1;
            tap_ifmap  <= ifm[ACT_W-1:0];
            tap_weight <= wgt[ACT_W-1:0];
            prod  = $signed(ifm[ACT_W-1:0]) * $signed(wgt[ACT_W-1:0]);
            sum_m = sum_m + prod;          // Wraps modulo 2^16
        end
        @(posedge clk);
        tap_push <= 1'b0;
        @(negedge clk);                    // Last tap taken, MAC has left ACC
        check_val("busy", 32'd1, 32'(busy));
    endtask

    task automatic do_expect();
        logic [PSUM_W-1:0] model;
        int                n;
        scan_n = $fscanf(fd, "%h", a);
        model = sum_m;
        if (ipsum_en_m && ipsum_q.size() > 0)
            model = model + ipsum_q.pop_front();   // Head of the queue
        assert (a == 32'(model)) else
            report_fail($sformatf("Data file opsum %h differs from model %h", a, model));
        n = 0;
        while (opsum_q.size() == 0 && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        assert (opsum_q.size() > 0) else report_fail("Timeout, no opsum_valid pulse");
        if (opsum_q.size() > 0)
            check_val("opsum", 32'(model), 32'(opsum_q.pop_front()));
        wait_idle();
    endtask

    task automatic do_flag();
        logic [31:0] full_m;
        logic [31:0] empty_m;
        scan_n = $fscanf(fd, "%h %h", a, b);
        @(negedge clk);
        full_m  = 32'(ipsum_q.size() == FIFO_DEPTH);
        empty_m = 32'(ipsum_q.size() == 0);
        assert (a == full_m && b == empty_m) else report_fail("Data file flags differ from model");
        check_val("ipsum_full", full_m, 32'(ipsum_full));
        check_val("ipsum_empty", empty_m, 32'(ipsum_empty));
    endtask

    //======================================================================
    // Main sequence
    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        cfg_write   = 1'b0;
        cfg_addr    = '0;
        cfg_wdata   = '0;
        tap_push    = 1'b0;
        tap_ifmap   = '0;
        tap_weight  = '0;
        ipsum_push  = 1'b0;
        ipsum_burst = 1'b0;
        ipsum_data  = '0;
        ipsum_clear = 1'b0;
        taps_m      = TAPS_W'(1);          // Reset values of the config block
        ipsum_en_m  = 1'b0;
        sum_m       = '0;
        errors      = 0;
        checks      = 0;
        tests       = 0;
        failed      = 0;
        test_errs   = 0;
        cur_name    = "";
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        fd = $fopen("bench/pe_tests.txt", "r");
        assert (fd != 0) else report_fail("Cannot open bench/pe_tests.txt");
        while (fd != 0 && $fscanf(fd, "%s", tname) == 1) begin
            if (tname == "#") begin
                skip_line();               // Comment line
            end else begin
                if (tname != cur_name) begin
                    finish_test();
                    cur_name = tname;
                end
                scan_n = $fscanf(fd, "%s", cmd);
                case (cmd)
                    "cfg":    do_cfg();
                    "read":   do_read();
                    "push1":  do_push(1'b0);
                    "push2":  do_push(1'b1);
                    "clear":  do_clear();
                    "taps":   do_taps();
                    "expect": do_expect();
                    "flag":   do_flag();
                    default:  report_fail($sformatf("Unknown command %s", cmd));
                endcase
            end
        end
        if (fd != 0)
            $fclose(fd);
        finish_test();

        assert (opsum_q.size() == 0) else report_fail("Opsum pulses arrived that no test expected");
        $display("Tests %0d, failed %0d, checks %0d, errors %0d", tests, failed, checks, errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

// ==== bench/pe_tests.txt ====
# Columns: test name, command, operands (all hex)
# cfg addr data, read addr value, push1 v, push2 lo hi, clear, taps n (ifmap weight) x n, expect opsum, flag full empty
cfg_readback cfg 0 05
cfg_readback read 0 05
cfg_readback cfg 1 01
cfg_readback read 1 01
cfg_readback cfg 0 00
cfg_readback read 0 01
cfg_readback read 2 00
cfg_readback cfg 1 00
sum_neg cfg 0 03
sum_neg taps 3 05 fd 7f 02 80 7f
sum_neg expect c16f
ipsum_single cfg 1 01
ipsum_single cfg 0 04
ipsum_single push1 0100
ipsum_single taps 4 02 03 ff 04 10 10 f0 02
ipsum_single expect 01e2
burst_lanes cfg 0 02
burst_lanes push2 1000 2000
burst_lanes taps 2 01 01 01 01
burst_lanes expect 1002
burst_lanes taps 2 03 ff 01 01
burst_lanes expect 1ffe
burst_lanes flag 0 1
fifo_full cfg 0 01
fifo_full push1 0011
fifo_full push1 0022
fifo_full push1 0033
fifo_full push1 0044
fifo_full push1 0055
fifo_full push2 0066 0077
fifo_full flag 1 0
fifo_full taps 1 01 01
fifo_full expect 0012
fifo_full taps 1 02 02
fifo_full expect 0026
fifo_full taps 1 ff 01
fifo_full expect 0032
fifo_full taps 1 00 05
fifo_full expect 0044
fifo_full flag 0 1
clear_fifo push1 0aaa
clear_fifo push1 0bbb
clear_fifo flag 0 0
clear_fifo clear
clear_fifo flag 0 1
clear_fifo taps 1 04 04
clear_fifo push1 0123
clear_fifo expect 0133
clear_fifo flag 0 1

// ==== logic/ipsum_fifo.sv ====
//==========================================================================
// Ipsum FIFO, DEPTH entries of PSUM_W bits, DEPTH must be 2 or more
// Burst push (two entries) is taken only when the FIFO is empty
// Rejected pushes and pops on empty are dropped without any flag
// Pop data is registered, valid the cycle after the pop edge
//==========================================================================
`timescale 1ns/1ps

module ipsum_fifo #(
    parameter int DEPTH = 4                               // Entries
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      ipsum_fifo_reset_i, // Sync clear pulse
    input  logic                      push_en,
    input  logic                      push_mod,           // 0 single, 1 burst
    input  pe_pkg::psum_pair_u        push_data,
    output logic                      full,
    input  logic                      pop_en,
    output logic [pe_pkg::PSUM_W-1:0] pop_data,
    output logic                      empty
);
    import pe_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [PSUM_W-1:0] mem [DEPTH];    // Storage, no reset
    logic [PTR_W-1:0]  wr_ptr;         // Next slot to write
    logic [PTR_W-1:0]  rd_ptr;         // Next slot to read
    logic [CNT_W-1:0]  count;          // Valid entries
    logic [PSUM_W-1:0] data_out_q;
    logic              push_single;
    logic              push_burst;
    logic              pop_ok;

    // Pointer step with wrap at DEPTH
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1))
            return '0;
        else
            return ptr + 1'b1;
    endfunction

    assign full     = (count == CNT_W'(DEPTH));
    assign empty    = (count == '0);
    assign pop_data = data_out_q;

    //======================================================================
    // Acceptance, clear wins over everything
    assign push_single = push_en && !push_mod && !full  && !ipsum_fifo_reset_i;
    assign push_burst  = push_en &&  push_mod && empty  && !ipsum_fifo_reset_i;
    assign pop_ok      = pop_en  && !empty && !ipsum_fifo_reset_i;

    //======================================================================
    // Write side
    always_ff @(posedge clk) begin
        if (push_single) begin
            mem[wr_ptr] <= push_data.lanes.lo;
        end else if (push_burst) begin
            mem[wr_ptr]          <= push_data.lanes.lo;  // Lo lane pops first
            mem[ptr_inc(wr_ptr)] <= push_data.lanes.hi;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            wr_ptr <= '0;
        else if (ipsum_fifo_reset_i)
            wr_ptr <= '0;
        else if (push_burst)
            wr_ptr <= ptr_inc(ptr_inc(wr_ptr));  // Two slots
        else if (push_single)
            wr_ptr <= ptr_inc(wr_ptr);
    end

    //======================================================================
    // Read side
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            rd_ptr <= '0;
        else if (ipsum_fifo_reset_i)
            rd_ptr <= '0;
        else if (pop_ok)
            rd_ptr <= ptr_inc(rd_ptr);
    end

    // Output register, zeroed by reset or clear
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            data_out_q <= '0;
        else if (ipsum_fifo_reset_i)
            data_out_q <= '0;
        else if (pop_ok)
            data_out_q <= mem[rd_ptr];
    end

    //======================================================================
    // Occupancy
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            count <= '0;
        else if (ipsum_fifo_reset_i)
            count <= '0;
        else if (push_burst)
            count <= CNT_W'(2);            // Only from empty, no pop possible
        else if (push_single && !pop_ok)
            count <= count + 1'b1;
        else if (pop_ok && !push_single)
            count <= count - 1'b1;
        // Push and pop together, count holds
    end

endmodule

// ==== logic/pe_config.sv ====
//==========================================================================
// PE config registers, tap count and ipsum enable
// A written tap count of 0 is stored as 1
// Writes land on the next edge, readback follows cfg_addr directly
//==========================================================================
`timescale 1ns/1ps

module pe_config (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          cfg_write,   // Write strobe
    input  logic [pe_pkg::CFG_ADDR_W-1:0] cfg_addr,
    input  logic [7:0]                    cfg_wdata,
    output logic [7:0]                    cfg_rdata,   // Combinational readback
    output logic [pe_pkg::TAPS_W-1:0]     taps,        // Level to MAC
    output logic                          ipsum_en     // Level to MAC
);
    import pe_pkg::*;

    logic [TAPS_W-1:0] taps_wr;        // Write value after zero fixup

    // MAC never sees a zero tap count
    assign taps_wr = (cfg_wdata[TAPS_W-1:0] == '0) ? TAPS_W'(1)
                                                   : cfg_wdata[TAPS_W-1:0];

    //======================================================================
    // Register write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            taps     <= TAPS_W'(1);        // One tap after reset
            ipsum_en <= 1'b0;              // Ipsum path off
        end else if (cfg_write) begin
            case (cfg_addr)
                CFG_TAPS_ADDR: taps     <= taps_wr;
                CFG_CTRL_ADDR: ipsum_en <= cfg_wdata[0];
                default: ;                 // Unused addresses ignore writes
            endcase
        end
    end

    //======================================================================
    // Readback decode
    always_comb begin
        case (cfg_addr)
            CFG_TAPS_ADDR: cfg_rdata = {{(8 - TAPS_W){1'b0}}, taps};
            CFG_CTRL_ADDR: cfg_rdata = {7'd0, ipsum_en};
            default:       cfg_rdata = 8'd0;  // Unmapped
        endcase
    end

endmodule

// ==== logic/pe_mac.sv ====
//==========================================================================
// PE MAC controller, signed ACT_W x ACT_W products summed into PSUM_W
// Sums wrap, no saturation; taps arriving while busy are ignored
// With ipsum_en set, exactly one ipsum is popped per output
// No back-pressure on opsum, the valid pulse lasts one cycle
//==========================================================================
`timescale 1ns/1ps

module pe_mac (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [pe_pkg::TAPS_W-1:0]        taps,         // Taps per output
    input  logic                             ipsum_en,     // Add popped ipsum
    input  logic                             tap_push,     // Tap strobe
    input  logic signed [pe_pkg::ACT_W-1:0]  tap_ifmap,
    input  logic signed [pe_pkg::ACT_W-1:0]  tap_weight,
    output logic                             pop_en,       // To ipsum FIFO
    input  logic [pe_pkg::PSUM_W-1:0]        pop_data,     // Registered FIFO data
    input  logic                             empty,
    output logic                             busy,
    output logic                             opsum_valid,
    output logic [pe_pkg::PSUM_W-1:0]        opsum
);
    import pe_pkg::*;

    //======================================================================
    // FSM encoding
    localparam logic [1:0] ACC   = 2'd0;   // Taking taps
    localparam logic [1:0] FETCH = 2'd1;   // Pop ipsum or skip
    localparam logic [1:0] WAIT  = 2'd2;   // FIFO output register loading
    localparam logic [1:0] EMIT  = 2'd3;   // Opsum valid

    logic [1:0]               state;
    logic [1:0]               state_nxt;
    logic [TAPS_W-1:0]        tap_cnt;      // Taps taken so far
    logic [TAPS_W-1:0]        tap_cnt_inc;
    logic                     tap_take;
    logic                     tap_last;
    logic signed [2*ACT_W-1:0] prod;        // Full-width signed product
    logic [PSUM_W-1:0]        prod_ext;
    logic [PSUM_W-1:0]        acc;          // Running tap sum
    logic [PSUM_W-1:0]        addend;       // Ipsum or zero

    //======================================================================
    // Datapath
    assign prod     = tap_ifmap * tap_weight;   // Both operands signed
    assign prod_ext = PSUM_W'(prod);            // Sign extends

    assign tap_take    = (state == ACC) && tap_push;
    assign tap_cnt_inc = tap_cnt + 1'b1;
    assign tap_last    = (tap_cnt_inc == taps);

    // FIFO data only meaningful in WAIT
    assign addend = (state == WAIT) ? pop_data : '0;

    //======================================================================
    // Next state
    always_comb begin
        state_nxt = state;
        case (state)
            ACC: begin
                if (tap_take && tap_last)
                    state_nxt = FETCH;
            end
            FETCH: begin
                if (!ipsum_en)
                    state_nxt = EMIT;      // No ipsum, sum goes straight out
                else if (!empty)
                    state_nxt = WAIT;      // Pop issued this cycle
            end
            WAIT:    state_nxt = EMIT;
            EMIT:    state_nxt = ACC;
            default: state_nxt = ACC;
        endcase
    end

    // Pop held off until the FIFO has data
    assign pop_en = (state == FETCH) && ipsum_en && !empty;

    //======================================================================
    // State, counter and accumulator
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= ACC;
            tap_cnt <= '0;
            acc     <= '0;
        end else begin
            state <= state_nxt;
            if (state == EMIT) begin
                tap_cnt <= '0;             // Fresh output window
                acc     <= '0;
            end else if (tap_take) begin
                tap_cnt <= tap_cnt_inc;
                acc     <= acc + prod_ext; // Wraps modulo 2^PSUM_W
            end
        end
    end

    // Final add, loaded on the way into EMIT
    always_ff @(posedge clk) begin
        if (state_nxt == EMIT && state != EMIT)
            opsum <= acc + addend;
    end

    //======================================================================
    // Status
    assign busy        = (state != ACC);   // Sender must hold taps
    assign opsum_valid = (state == EMIT);  // One cycle, EMIT never repeats

endmodule

// ==== logic/pe_pkg.sv ====
//==========================================================================
// Shared widths and config map for one PE of the convolution accelerator
// Partial sums wrap modulo 2^PSUM_W, no saturation anywhere
// TAPS_W bounds the tap count to 1..2^TAPS_W-1
//==========================================================================
package pe_pkg;

    //======================================================================
    // Data widths
    localparam int PSUM_W = 16;  // Partial sum
    localparam int ACT_W  = 8;   // Ifmap and weight, signed
    localparam int TAPS_W = 4;   // Tap count register

    //======================================================================
    // Config register map
    localparam int CFG_ADDR_W = 2;

    localparam logic [CFG_ADDR_W-1:0] CFG_TAPS_ADDR = 2'd0;  // Tap count
    localparam logic [CFG_ADDR_W-1:0] CFG_CTRL_ADDR = 2'd1;  // Bit 0 ipsum_en

    //======================================================================
    // Ipsum push word
    // Single push takes lanes.lo only
    // Burst push stores lo first, then hi
    typedef union packed {
        logic [2*PSUM_W-1:0] raw;
        struct packed {
            logic [PSUM_W-1:0] hi;  // Second entry of a burst
            logic [PSUM_W-1:0] lo;  // Single push, first of a burst
        } lanes;
    } psum_pair_u;

endpackage

// ==== logic/pe_top.sv ====
//==========================================================================
// Processing element top, config block, MAC controller and ipsum FIFO
// FIFO_DEPTH must be 2 or more; taps must not be pushed while busy
// Opsum has no back-pressure, sample it on opsum_valid
//==========================================================================
`timescale 1ns/1ps

module pe_top #(
    parameter int FIFO_DEPTH = 4                          // Ipsum entries
) (
    input  logic                          clk,
    input  logic                          rst_n,
    // Config access
    input  logic                          cfg_write,
    input  logic [pe_pkg::CFG_ADDR_W-1:0] cfg_addr,
    input  logic [7:0]                    cfg_wdata,
    output logic [7:0]                    cfg_rdata,
    // Tap stream
    input  logic                          tap_push,
    input  logic [pe_pkg::ACT_W-1:0]      tap_ifmap,      // Signed
    input  logic [pe_pkg::ACT_W-1:0]      tap_weight,     // Signed
    // Ipsum input
    input  logic                          ipsum_push,
    input  logic                          ipsum_burst,    // Two entries
    input  pe_pkg::psum_pair_u            ipsum_data,
    input  logic                          ipsum_clear,
    // Results and status
    output logic                          opsum_valid,
    output logic [pe_pkg::PSUM_W-1:0]     opsum,
    output logic                          busy,
    output logic                          ipsum_full,
    output logic                          ipsum_empty
);
    import pe_pkg::*;

    logic [TAPS_W-1:0] taps;           // Config to MAC
    logic              ipsum_en;
    logic              pop_en;         // MAC to FIFO
    logic [PSUM_W-1:0] pop_data;       // FIFO to MAC

    //======================================================================
    // Config registers
    pe_config i_config (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_write (cfg_write),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata),
        .taps      (taps),
        .ipsum_en  (ipsum_en)
    );

    // MAC controller
    pe_mac i_mac (
        .clk         (clk),
        .rst_n       (rst_n),
        .taps        (taps),
        .ipsum_en    (ipsum_en),
        .tap_push    (tap_push),
        .tap_ifmap   (tap_ifmap),
        .tap_weight  (tap_weight),
        .pop_en      (pop_en),
        .pop_data    (pop_data),
        .empty       (ipsum_empty),
        .busy        (busy),
        .opsum_valid (opsum_valid),
        .opsum       (opsum)
    );

    // Ipsum FIFO, push side straight from the ports
    ipsum_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) i_ipsum_fifo (
        .clk                (clk),
        .rst_n              (rst_n),
        .ipsum_fifo_reset_i (ipsum_clear),
        .push_en            (ipsum_push),
        .push_mod           (ipsum_burst),
        .push_data          (ipsum_data),
        .full               (ipsum_full),
        .pop_en             (pop_en),
        .pop_data           (pop_data),
        .empty              (ipsum_empty)
    );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build pe_tb with Verilator from the project root and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module pe_tb -f src.f -o pe_sim

out=$(./obj_dir/pe_sim)
echo "$out"
echo "$out" | grep -qx "NO ERRORS"

// ==== src.f ====
logic/pe_pkg.sv
logic/ipsum_fifo.sv
logic/pe_config.sv
logic/pe_mac.sv
logic/pe_top.sv
bench/pe_assert.sv
bench/pe_tb.sv
